// ==== rtl/brq_pkg.sv ====
`default_nettype none

package brq_pkg;

    // ##################################################
    // Sizes and field widths
    // ##################################################

    localparam int NUM_REQ  = 11;  // Requesters on the bus.
    localparam int QDEPTH   = 11;  // Queue slots.
    localparam int REQ_W    = 8;   // Sender id plus destination.
    localparam int ID_W     = 4;   // Upper nibble.
    localparam int DEST_W   = 4;   // Lower nibble.
    localparam int NUM_DEST = 9;   // Free lines.

    // Bit positions of the free lines in the packed free vector.
    localparam int FREE_IE  = 0;
    localparam int FREE_IO  = 1;
    localparam int FREE_DE  = 2;
    localparam int FREE_DO  = 3;
    localparam int FREE_B0  = 4;
    localparam int FREE_B1  = 5;
    localparam int FREE_B2  = 6;
    localparam int FREE_B3  = 7;
    localparam int FREE_DMA = 8;

    // ##################################################
    // Destination codes
    // ##################################################

    // Bit 1 is a don't care for the instruction and data codes.
    // 13 to 15 are reserved and never dispatch.
    typedef enum logic [DEST_W-1:0] {
        DEST_IE  = 4'd0,
        DEST_IO  = 4'd1,
        DEST_DE  = 4'd4,
        DEST_DO  = 4'd5,
        DEST_B0  = 4'd8,
        DEST_B1  = 4'd9,
        DEST_B2  = 4'd10,
        DEST_B3  = 4'd11,
        DEST_DMA = 4'd12
    } dest_code_e;

endpackage

`default_nettype wire

// ==== rtl/req_intake.sv ====
`default_nettype none

module req_intake (
    input  logic [brq_pkg::NUM_REQ-1:0]               req,
    input  logic [brq_pkg::NUM_REQ*brq_pkg::REQ_W-1:0] req_data,
    input  logic                                       slot0_load,
    output logic [brq_pkg::REQ_W-1:0]                  in_entry,
    output logic                                       in_valid,
    output logic [brq_pkg::NUM_REQ-1:0]                ack
);

    logic [brq_pkg::NUM_REQ-1:0] sel;  // One-hot winner.

    // ##################################################
    // Fixed priority, highest index wins
    // ##################################################

    always_comb begin
        sel = '0;
        for (int i = 0; i < brq_pkg::NUM_REQ; i++) begin
            if (req[i]) begin
                sel    = '0;  // Later index overrides.
                sel[i] = 1'b1;
            end
        end
    end

    // One-hot mux of the winner's request.
    always_comb begin
        in_entry = '0;
        for (int i = 0; i < brq_pkg::NUM_REQ; i++) begin
            in_entry = in_entry
                     | ({brq_pkg::REQ_W{sel[i]}} & req_data[i*brq_pkg::REQ_W +: brq_pkg::REQ_W]);
        end
    end

    assign in_valid = |req;
    assign ack      = sel & {brq_pkg::NUM_REQ{slot0_load}};  // Only when slot 0 takes it.

endmodule

`default_nettype wire

// ==== rtl/collapse_queue.sv ====
`default_nettype none

module collapse_queue (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic [brq_pkg::REQ_W-1:0]                 in_entry,
    input  logic                                      in_valid,
    input  logic [brq_pkg::QDEPTH-1:0]                grant,
    output logic [brq_pkg::QDEPTH-1:0]                entry_valid,
    output logic [brq_pkg::QDEPTH*brq_pkg::REQ_W-1:0] entry_data,
    output logic                                      slot0_load
);

    logic [brq_pkg::QDEPTH-1:0] slot_valid;
    logic [brq_pkg::REQ_W-1:0]  slot_data [brq_pkg::QDEPTH];
    logic [brq_pkg::QDEPTH-1:0] hole;  // Empty or leaving this cycle.
    logic [brq_pkg::QDEPTH-1:0] load;

    // ##################################################
    // Load enables
    // ##################################################

    assign hole = ~slot_valid | grant;

    // A slot shifts when any slot at or above it has room.
    always_comb begin
        load[brq_pkg::QDEPTH-1] = hole[brq_pkg::QDEPTH-1];
        for (int k = brq_pkg::QDEPTH - 2; k >= 0; k--) begin
            load[k] = load[k+1] | hole[k];
        end
    end

    assign slot0_load = load[0];

    // ##################################################
    // Slot registers
    // ##################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_valid <= '0;
        end else begin
            if (load[0]) begin
                slot_valid[0] <= in_valid;
            end
            for (int k = 1; k < brq_pkg::QDEPTH; k++) begin
                if (load[k]) begin
                    slot_valid[k] <= slot_valid[k-1] & ~grant[k-1];  // Drop a granted entry.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load[0]) begin
            slot_data[0] <= in_entry;
        end
        for (int k = 1; k < brq_pkg::QDEPTH; k++) begin
            if (load[k]) begin
                slot_data[k] <= slot_data[k-1];
            end
        end
    end

    // Flatten for the dispatch side.
    always_comb begin
        for (int k = 0; k < brq_pkg::QDEPTH; k++) begin
            entry_data[k*brq_pkg::REQ_W +: brq_pkg::REQ_W] = slot_data[k];
        end
    end

    assign entry_valid = slot_valid;

endmodule

`default_nettype wire

// ==== rtl/dispatch_select.sv ====
`default_nettype none

module dispatch_select (
    input  logic [brq_pkg::QDEPTH-1:0]                entry_valid,
    input  logic [brq_pkg::QDEPTH*brq_pkg::REQ_W-1:0] entry_data,
    input  logic                                      free_ie,
    input  logic                                      free_io,
    input  logic                                      free_de,
    input  logic                                      free_do,
    input  logic                                      free_b0,
    input  logic                                      free_b1,
    input  logic                                      free_b2,
    input  logic                                      free_b3,
    input  logic                                      free_dma,
    input  logic                                      pull,
    output logic [brq_pkg::QDEPTH-1:0]                grant,
    output logic                                      req_ready,
    output logic [brq_pkg::ID_W-1:0]                  send_out,
    output logic [brq_pkg::DEST_W-1:0]                dest_out
);

    logic [brq_pkg::NUM_DEST-1:0] free_vec;
    logic [brq_pkg::QDEPTH-1:0]   ready;
    logic [brq_pkg::QDEPTH-1:0]   older_ready;  // Some older slot is ready.

    assign free_vec = {free_dma, free_b3, free_b2, free_b1, free_b0,
                       free_do, free_de, free_io, free_ie};

    // Free line of a destination, 0 for reserved codes.
    function automatic logic dest_free(input logic [brq_pkg::DEST_W-1:0]   dest,
                                       input logic [brq_pkg::NUM_DEST-1:0] fv);
        brq_pkg::dest_code_e code;
        code = brq_pkg::dest_code_e'({dest[3:2], dest[1] & dest[3], dest[0]});  // Mask bit 1.
        case (code)
            brq_pkg::DEST_IE:  dest_free = fv[brq_pkg::FREE_IE];
            brq_pkg::DEST_IO:  dest_free = fv[brq_pkg::FREE_IO];
            brq_pkg::DEST_DE:  dest_free = fv[brq_pkg::FREE_DE];
            brq_pkg::DEST_DO:  dest_free = fv[brq_pkg::FREE_DO];
            brq_pkg::DEST_B0:  dest_free = fv[brq_pkg::FREE_B0];
            brq_pkg::DEST_B1:  dest_free = fv[brq_pkg::FREE_B1];
            brq_pkg::DEST_B2:  dest_free = fv[brq_pkg::FREE_B2];
            brq_pkg::DEST_B3:  dest_free = fv[brq_pkg::FREE_B3];
            brq_pkg::DEST_DMA: dest_free = fv[brq_pkg::FREE_DMA];
            default:           dest_free = 1'b0;
        endcase
    endfunction

    // ##################################################
    // Readiness and oldest-first grant
    // ##################################################

    always_comb begin
        for (int k = 0; k < brq_pkg::QDEPTH; k++) begin
            ready[k] = entry_valid[k] & pull
                     & dest_free(entry_data[k*brq_pkg::REQ_W +: brq_pkg::DEST_W], free_vec);
        end
    end

    always_comb begin
        older_ready[brq_pkg::QDEPTH-1] = 1'b0;
        for (int k = brq_pkg::QDEPTH - 2; k >= 0; k--) begin
            older_ready[k] = older_ready[k+1] | ready[k+1];
        end
    end

    assign grant     = ready & ~older_ready;
    assign req_ready = |ready;

    // One-hot output mux, zero without a grant.
    always_comb begin
        send_out = '0;
        dest_out = '0;
        for (int k = 0; k < brq_pkg::QDEPTH; k++) begin
            send_out = send_out | ({brq_pkg::ID_W{grant[k]}}
                     & entry_data[k*brq_pkg::REQ_W + brq_pkg::DEST_W +: brq_pkg::ID_W]);
            dest_out = dest_out | ({brq_pkg::DEST_W{grant[k]}}
                     & entry_data[k*brq_pkg::REQ_W +: brq_pkg::DEST_W]);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bus_req_queue.sv ====
`default_nettype none

module bus_req_queue (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic [brq_pkg::NUM_REQ-1:0]                req,
    input  logic [brq_pkg::NUM_REQ*brq_pkg::REQ_W-1:0] req_data,
    input  logic                                       free_ie,
    input  logic                                       free_io,
    input  logic                                       free_de,
    input  logic                                       free_do,
    input  logic                                       free_b0,
    input  logic                                       free_b1,
    input  logic                                       free_b2,
    input  logic                                       free_b3,
    input  logic                                       free_dma,
    input  logic                                       pull,
    output logic [brq_pkg::NUM_REQ-1:0]                ack,
    output logic                                       req_ready,
    output logic [brq_pkg::ID_W-1:0]                   send_out,
    output logic [brq_pkg::DEST_W-1:0]                 dest_out
);

    logic [brq_pkg::REQ_W-1:0]                  in_entry;
    logic                                       in_valid;
    logic                                       slot0_load;
    logic [brq_pkg::QDEPTH-1:0]                 entry_valid;
    logic [brq_pkg::QDEPTH*brq_pkg::REQ_W-1:0]  entry_data;
    logic [brq_pkg::QDEPTH-1:0]                 grant;

    req_intake intake0 (
        .req        (req),
        .req_data   (req_data),
        .slot0_load (slot0_load),
        .in_entry   (in_entry),
        .in_valid   (in_valid),
        .ack        (ack)
    );

    collapse_queue queue0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_entry    (in_entry),
        .in_valid    (in_valid),
        .grant       (grant),
        .entry_valid (entry_valid),
        .entry_data  (entry_data),
        .slot0_load  (slot0_load)
    );

    dispatch_select dispatch0 (
        .entry_valid (entry_valid),
        .entry_data  (entry_data),
        .free_ie     (free_ie),
        .free_io     (free_io),
        .free_de     (free_de),
        .free_do     (free_do),
        .free_b0     (free_b0),
        .free_b1     (free_b1),
        .free_b2     (free_b2),
        .free_b3     (free_b3),
        .free_dma    (free_dma),
        .pull        (pull),
        .grant       (grant),
        .req_ready   (req_ready),
        .send_out    (send_out),
        .dest_out    (dest_out)
    );

endmodule

`default_nettype wire

// ==== test/tb_bus_req_queue.sv ====
`default_nettype none

module tb_bus_req_queue;
    timeunit 1ns;
    timeprecision 100ps;

    logic                                       clk = 1'b0;
    logic                                       arst_n;
    logic [brq_pkg::NUM_REQ-1:0]                req;
    logic [brq_pkg::NUM_REQ*brq_pkg::REQ_W-1:0] req_data;
    logic [brq_pkg::NUM_DEST-1:0]               free_drv;  // Bit 0 ie up to bit 8 dma.
    logic                                       pull;
    logic [brq_pkg::NUM_REQ-1:0]                ack;
    logic                                       req_ready;
    logic [brq_pkg::ID_W-1:0]                   send_out;
    logic [brq_pkg::DEST_W-1:0]                 dest_out;

    string ph_name[$];
    int    ph_req[$], ph_free[$], ph_pull[$], ph_cycles[$], ph_rsv[$], ph_acks[$];

    logic [brq_pkg::REQ_W-1:0]   req_vals [brq_pkg::NUM_REQ];  // Next data per requester.
    logic [brq_pkg::NUM_REQ-1:0] pend = '0;  // Requests still waiting for ack.
    logic [brq_pkg::REQ_W-1:0]   model_q[$];  // Oldest entry at index 0.
    string                       cur_name = "reset";
    int                          limit = 0;
    int                          cycle_cnt = 0;
    int                          acks_seen;

    brq_pkg::dest_code_e code_pool[9] = '{brq_pkg::DEST_IE, brq_pkg::DEST_IO, brq_pkg::DEST_DE,
                                          brq_pkg::DEST_DO, brq_pkg::DEST_B0, brq_pkg::DEST_B1,
                                          brq_pkg::DEST_B2, brq_pkg::DEST_B3, brq_pkg::DEST_DMA};

    bus_req_queue dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .req_data  (req_data),
        .free_ie   (free_drv[0]),
        .free_io   (free_drv[1]),
        .free_de   (free_drv[2]),
        .free_do   (free_drv[3]),
        .free_b0   (free_drv[4]),
        .free_b1   (free_drv[5]),
        .free_b2   (free_drv[6]),
        .free_b3   (free_drv[7]),
        .free_dma  (free_drv[8]),
        .pull      (pull),
        .ack       (ack),
        .req_ready (req_ready),
        .send_out  (send_out),
        .dest_out  (dest_out)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (limit > 0 && cycle_cnt >= limit) begin
            $display("Run did not finish within %0d cycles.", limit);
            $display("TEST FAILED");
            $fatal(1, "Cycle limit reached.");
        end
    end

    // ##################################################
    // Helpers
    // ##################################################

    function automatic logic line_free(input logic [3:0] dest, input logic [8:0] fm);
        case (dest[3:2])
            2'b00:   line_free = dest[0] ? fm[1] : fm[0];  // Instruction ignores bit 1.
            2'b01:   line_free = dest[0] ? fm[3] : fm[2];
            2'b10:   line_free = fm[4 + dest[1:0]];
            default: line_free = (dest[1:0] == 2'b00) ? fm[8] : 1'b0;  // 13 to 15 reserved.
        endcase
    endfunction

    function automatic logic [7:0] draw_request(input int rsv);
        logic [3:0] id;
        logic [3:0] dest;
        id = 4'($urandom);
        if (rsv != 0) begin
            dest = 4'(13 + $urandom_range(2, 0));
        end else begin
            dest = code_pool[$urandom_range(8, 0)];
            if (!dest[3]) begin
                dest[1] = 1'($urandom);  // Aliases share a free line.
            end
        end
        return {id, dest};
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s.", what);
        end
    endtask

    task automatic read_cases();
        int    fd;
        int    n;
        string line;
        string nm;
        int    rq, fr, pl, cy, rs, ea;
        fd = $fopen("test/brq_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file test/brq_cases.txt.");
            $display("TEST FAILED");
            $fatal(1, "No cases file.");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %d %d %d %d", nm, rq, fr, pl, cy, rs, ea);
                    if (n == 7) begin
                        ph_name.push_back(nm);
                        ph_req.push_back(rq);
                        ph_free.push_back(fr);
                        ph_pull.push_back(pl);
                        ph_cycles.push_back(cy);
                        ph_rsv.push_back(rs);
                        ph_acks.push_back(ea);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ##################################################
    // One clock cycle against the model
    // ##################################################

    task automatic run_cycle(input int p);
        logic [brq_pkg::NUM_REQ-1:0] req_drv;
        logic [brq_pkg::NUM_REQ-1:0] exp_ack;
        logic [8:0]                  fm;
        logic                        pl;
        logic                        accept;
        logic [7:0]                  sent;
        int                          gidx;
        int                          win;
        fm      = 9'(ph_free[p]);
        pl      = (ph_pull[p] != 0);
        req_drv = 11'(ph_req[p]) | pend;
        @(negedge clk);
        req      = req_drv;
        pull     = pl;
        free_drv = fm;
        for (int i = 0; i < brq_pkg::NUM_REQ; i++) begin
            req_data[i*brq_pkg::REQ_W +: brq_pkg::REQ_W] = req_vals[i];
        end
        #2;
        gidx = -1;  // Oldest entry with a free line.
        for (int k = 0; k < model_q.size(); k++) begin
            if (gidx < 0 && pl && line_free(model_q[k][3:0], fm)) begin
                gidx = k;
            end
        end
        win = -1;
        for (int i = 0; i < brq_pkg::NUM_REQ; i++) begin
            if (req_drv[i]) begin
                win = i;
            end
        end
        accept  = (win >= 0) && (model_q.size() < brq_pkg::QDEPTH || gidx >= 0);
        exp_ack = '0;
        if (accept) begin
            exp_ack[win] = 1'b1;
        end
        sent = (gidx >= 0) ? model_q[gidx] : 8'h00;
        check("ack", 32'(exp_ack), 32'(ack));
        check("req_ready", 32'(gidx >= 0), 32'(req_ready));
        check("send_out", 32'(sent[7:4]), 32'(send_out));
        check("dest_out", 32'(sent[3:0]), 32'(dest_out));
        acks_seen += $countones(ack);
        if (gidx >= 0) begin
            model_q.delete(gidx);
        end
        if (accept) begin
            model_q.push_back(req_vals[win]);
            req_vals[win] = draw_request(ph_rsv[p]);  // Next request of that unit.
        end
        pend = req_drv & ~exp_ack;
    endtask

    task automatic run_phase(input int p);
        cur_name  = ph_name[p];
        acks_seen = 0;
        for (int i = 0; i < brq_pkg::NUM_REQ; i++) begin
            if (!pend[i]) begin
                req_vals[i] = draw_request(ph_rsv[p]);
            end
        end
        repeat (ph_cycles[p]) run_cycle(p);
        check("ack count", 32'(ph_acks[p]), 32'(acks_seen));
    endtask

    // ##################################################
    // Main sequence
    // ##################################################

    initial begin
        void'($urandom(79));
        arst_n   = 1'b0;
        req      = '0;
        req_data = '0;
        free_drv = '0;
        pull     = 1'b0;
        read_cases();
        limit = 50;
        foreach (ph_cycles[p]) begin
            limit += ph_cycles[p];
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        foreach (ph_name[p]) begin
            run_phase(p);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/brq_cases.txt ====
# name req_mask(hex) free_mask(hex, bit 0 ie to bit 8 dma) pull cycles reserved exp_acks
# reserved 1 draws destination codes 13 to 15 for new requests; exp_acks counts ack pulses
idle         000 1ff 1  4 0  0
intake       7ff 000 0  6 0  6
drain        000 1ff 1  8 0  8
bypass       000 0f0 1  6 0  2
flush        000 1ff 1 12 0  0
fill         7ff 1ff 0 14 0 11
full_pull    7ff 1ff 1  4 0  4
flush_full   000 1ff 1 24 0 10
reserved     7ff 1ff 1 14 1 11
stuck        000 1ff 1  4 1  0

// ==== compile.f ====
rtl/brq_pkg.sv
rtl/req_intake.sv
rtl/collapse_queue.sv
rtl/dispatch_select.sv
rtl/bus_req_queue.sv
test/tb_bus_req_queue.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the bus request queue testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_bus_req_queue -f compile.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "Build or simulation returned an error."
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && echo "Simulation passed." || { echo "Simulation failed."; exit 1; }
